/* src.f */
logic/lspPkg.sv
logic/scratchMemory.sv
logic/basicOps.sv
logic/memPortArbiter.sv
logic/lspPrevUpdate.sv
logic/lspUpdateTop.sv
tb/lspUpdateChecker.sv
tb/lspUpdateTb.sv

/* Makefile */
# Verilator simulation of the LSP history update

VERILATOR ?= verilator
TOP       ?= lspUpdateTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/lspUpdateTb.sv */
`default_nettype none

module lspUpdateTb;

	localparam int aw = lspPkg::addrWidth;
	localparam int dw = lspPkg::dataWidth;
	localparam int driveDelay = 2;
	localparam int resetCycles = 16;
	localparam int rounds = 20;
	localparam int warmWords = 16;
	localparam int maxGap = 2;
	localparam int maxHold = 20;
	localparam int blockWords = lspPkg::maNp * lspPkg::lpcOrder + lspPkg::lpcOrder;
	// Preload, readback and the extra host requests, each at most maxGap idle cycles
	localparam int roundCycles = (2 * blockWords + 3) * (maxGap + 1)
		+ lspPkg::updateLatency + maxHold + 20;
	localparam int cycleLimit = resetCycles + 2 * warmWords * (maxGap + 1)
		+ rounds * roundCycles + 100;

	localparam logic [aw-1:0] fpBase = aw'(64);
	localparam logic [aw-1:0] leBase = aw'(1024);

	logic           clk;
	logic           rstN;
	logic           hostValid;
	logic           hostWrite;
	logic [aw-1:0]  hostAddr;
	logic [dw-1:0]  hostWdata;
	logic           hostReady;
	logic           rdValid;
	logic [dw-1:0]  rdData;
	logic           startValid;
	logic           startReady;
	logic           done;
	logic [aw-1:0]  freqPrevBase;
	logic [aw-1:0]  lspEleBase;

	// Reference copy of the scratch memory
	logic [dw-1:0]  model [0:(1 << aw)-1];
	logic [dw-1:0]  expRdWord;
	logic [31:0]    lcgState = 32'hf20d;
	logic [aw-1:0]  warmAddrs [$];

	int errorCount;
	int checkCount;
	int tbErrors = 0;
	int cycleCount = 0;
	int startCount = 0;
	int doneCount = 0;

	assign expRdWord = model[hostAddr];

	lspUpdateTop lspUpdateTop_inst
	(
		.clk          (clk),
		.rstN         (rstN),
		.hostValid    (hostValid),
		.hostWrite    (hostWrite),
		.hostAddr     (hostAddr),
		.hostWdata    (hostWdata),
		.hostReady    (hostReady),
		.rdValid      (rdValid),
		.rdData       (rdData),
		.startValid   (startValid),
		.startReady   (startReady),
		.done         (done),
		.freqPrevBase (freqPrevBase),
		.lspEleBase   (lspEleBase)
	);

	lspUpdateChecker lspUpdateChecker_inst
	(
		.clk        (clk),
		.rstN       (rstN),
		.hostValid  (hostValid),
		.hostWrite  (hostWrite),
		.hostReady  (hostReady),
		.rdValid    (rdValid),
		.rdData     (rdData),
		.startValid (startValid),
		.startReady (startReady),
		.done       (done),
		.expRdWord  (expRdWord),
		.errorCount (errorCount),
		.checkCount (checkCount)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(negedge clk)
	begin
		if (rstN && done)
			doneCount++;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, %0d errors so far", cycleCount, errorCount + tbErrors);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Random numbers and addresses
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	function automatic int pickBelow(input int n);
		return int'(nextRandom()) % n;
	endfunction

	function automatic logic [aw-1:0] rowAddress(input int k, input int i);
		return fpBase + aw'(k * lspPkg::rowStride + i);
	endfunction

	function automatic logic [aw-1:0] eleAddress(input int i);
		return leBase + aw'(i);
	endfunction

	// Any address outside the history and lsp_ele blocks
	function automatic logic [aw-1:0] freeAddress();
		logic [aw-1:0] a;
		a = aw'(nextRandom());
		if ((a >= fpBase && a < fpBase + aw'(lspPkg::maNp * lspPkg::rowStride))
			|| (a >= leBase && a < leBase + aw'(lspPkg::rowStride)))
			a = a ^ aw'(512);
		return a;
	endfunction

	////////////////////////////////////////////////////////////
	// Host and start drivers
	////////////////////////////////////////////////////////////

	task automatic nextCycle();
		@(posedge clk);
		#driveDelay;
	endtask

	task automatic hostRequest(input logic isWrite, input logic [aw-1:0] addr,
		input logic [dw-1:0] data);
		logic granted;
		hostValid = 1'b1;
		hostWrite = isWrite;
		hostAddr  = addr;
		hostWdata = data;
		granted   = 1'b0;
		while (!granted)
		begin
			@(negedge clk);
			granted = hostReady;
			nextCycle();
		end
		hostValid = 1'b0;
		if (isWrite)
			model[addr] = data;
	endtask

	task automatic gapRequest(input logic isWrite, input logic [aw-1:0] addr,
		input logic [dw-1:0] data);
		repeat (pickBelow(maxGap + 1)) nextCycle();
		hostRequest(isWrite, addr, data);
	endtask

	// Shift rule: rows move down by one, lsp_ele enters row 0
	task automatic applyShift();
		int i;
		int k;
		for (i = 0; i < lspPkg::lpcOrder; i++)
		begin
			for (k = lspPkg::maNp - 1; k > 0; k--)
				model[rowAddress(k, i)] = model[rowAddress(k - 1, i)];
			model[rowAddress(0, i)] = model[eleAddress(i)];
		end
	endtask

	task automatic startUpdate(input logic withHostRead);
		logic accepted;
		logic granted;
		startValid = 1'b1;
		if (withHostRead)
		begin
			hostValid = 1'b1;
			hostWrite = 1'b0;
			hostAddr  = eleAddress(pickBelow(lspPkg::lpcOrder));
		end
		accepted = 1'b0;
		while (!accepted)
		begin
			@(negedge clk);
			accepted = startReady;
			granted  = hostValid && hostReady;
			nextCycle();
			if (granted)
				hostValid = 1'b0;
		end
		startCount++;
		applyShift();
		// Start stays raised into the update
		repeat (1 + pickBelow(maxHold)) nextCycle();
		startValid = 1'b0;
	endtask

	task automatic runRound(input int round);
		int k;
		int i;
		logic [aw-1:0] extraAddr;
		for (k = 0; k < lspPkg::maNp; k++)
			for (i = 0; i < lspPkg::lpcOrder; i++)
				gapRequest(1'b1, rowAddress(k, i), nextRandom());
		for (i = 0; i < lspPkg::lpcOrder; i++)
			gapRequest(1'b1, eleAddress(i), nextRandom());
		startUpdate(round % 2 == 1);
		// Raised while busy, waits for the update to end
		extraAddr = freeAddress();
		hostRequest(1'b1, extraAddr, nextRandom());
		while (doneCount < startCount)
			nextCycle();
		for (k = 0; k < lspPkg::maNp; k++)
			for (i = 0; i < lspPkg::lpcOrder; i++)
				gapRequest(1'b0, rowAddress(k, i), '0);
		for (i = 0; i < lspPkg::lpcOrder; i++)
			gapRequest(1'b0, eleAddress(i), '0);
		gapRequest(1'b0, extraAddr, '0);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int r;
		logic [aw-1:0] a;
		rstN         = 1'b0;
		hostValid    = 1'b0;
		hostWrite    = 1'b0;
		hostAddr     = '0;
		hostWdata    = '0;
		startValid   = 1'b0;
		freqPrevBase = fpBase;
		lspEleBase   = leBase;
		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		rstN = 1'b1;
		nextCycle();

		// Plain host traffic outside both blocks
		for (r = 0; r < warmWords; r++)
		begin
			a = freeAddress();
			warmAddrs.push_back(a);
			gapRequest(1'b1, a, nextRandom());
		end
		foreach (warmAddrs[r])
			gapRequest(1'b0, warmAddrs[r], '0);

		for (r = 0; r < rounds; r++)
			runRound(r);
		repeat (4) nextCycle();

		if (doneCount != startCount)
		begin
			tbErrors++;
			$display("done pulsed %0d times for %0d accepted starts", doneCount, startCount);
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount + tbErrors);
		if (errorCount + tbErrors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/lspUpdateChecker.sv */
`default_nettype none

module lspUpdateChecker
(
	input  wire logic                          clk,
	input  wire logic                          rstN,
	input  wire logic                          hostValid,
	input  wire logic                          hostWrite,
	input  wire logic                          hostReady,
	input  wire logic                          rdValid,
	input  wire logic [lspPkg::dataWidth-1:0]  rdData,
	input  wire logic                          startValid,
	input  wire logic                          startReady,
	input  wire logic                          done,
	// Model word at the current host address
	input  wire logic [lspPkg::dataWidth-1:0]  expRdWord,
	output      int                            errorCount,
	output      int                            checkCount
);

	int errors = 0;
	int checks = 0;

	logic                          updating;
	int                            age;
	logic                          inUpdate;
	logic                          doneDue;
	logic                          rdPending;
	logic [lspPkg::dataWidth-1:0]  rdExpected;

	assign errorCount = errors;
	assign checkCount = checks;

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("[ERROR] %0t %s: got 'h%h, expected 'h%h", $time, name, got, expected);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Sampled mid cycle, when all DUT outputs have settled
	////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (!rstN)
		begin
			updating  = 1'b0;
			age       = 0;
			rdPending = 1'b0;
		end
		else
		begin
			// Age counts cycles since the accepted start
			if (updating)
				age = age + 1;
			inUpdate = updating && age >= 1 && age < lspPkg::updateLatency;
			doneDue  = updating && age == lspPkg::updateLatency;

			compareValue("done", done, doneDue);
			if (inUpdate)
			begin
				compareValue("hostReady", hostReady, 1'b0);
				compareValue("startReady", startReady, 1'b0);
			end
			else
			begin
				compareValue("hostReady", hostReady, 1'b1);
				// Host request wins over start
				compareValue("startReady", startReady, !hostValid);
			end
			if (doneDue)
				updating = 1'b0;

			// Fixed one cycle read response
			compareValue("rdValid", rdValid, rdPending);
			if (rdPending)
				compareValue("rdData", rdData, rdExpected);
			rdPending  = hostValid && hostReady && !hostWrite;
			rdExpected = expRdWord;

			if (startValid && startReady)
			begin
				if (updating)
				begin
					errors++;
					$display("%0t start was accepted while an update was still running", $time);
				end
				updating = 1'b1;
				age      = 0;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/lspUpdateTop.sv */
`default_nettype none

module lspUpdateTop
(
	input  wire logic                          clk,
	input  wire logic                          rstN,

	// Host port
	input  wire logic                          hostValid,
	input  wire logic                          hostWrite,
	input  wire logic [lspPkg::addrWidth-1:0]  hostAddr,
	input  wire logic [lspPkg::dataWidth-1:0]  hostWdata,
	output      logic                          hostReady,
	output      logic                          rdValid,
	output      logic [lspPkg::dataWidth-1:0]  rdData,

	// Update control
	input  wire logic                          startValid,
	output      logic                          startReady,
	output      logic                          done,
	input  wire logic [lspPkg::addrWidth-1:0]  freqPrevBase,
	input  wire logic [lspPkg::addrWidth-1:0]  lspEleBase
);

	localparam int aw = lspPkg::addrWidth;
	localparam int dw = lspPkg::dataWidth;

	// Engine to arbiter
	logic           busy;
	logic           hostGrant;
	logic           engRdEn;
	logic [aw-1:0]  engRdAddr;
	logic           engWrEn;
	logic [aw-1:0]  engWrAddr;
	logic [dw-1:0]  engWdata;

	// Arbiter to memory
	logic           memWrEn;
	logic [aw-1:0]  memWrAddr;
	logic [dw-1:0]  memWrData;
	logic [aw-1:0]  memRdAddr;
	logic [dw-1:0]  memRdData;

	// Engine to operator unit
	logic [dw-1:0]  opA;
	logic [dw-1:0]  opB;
	logic           opSel;
	logic [dw-1:0]  opResult;
	logic           opOverflow;

	scratchMemory scratchMemory_inst
	(
		.clk    (clk),
		.wrEn   (memWrEn),
		.wrAddr (memWrAddr),
		.wrData (memWrData),
		.rdAddr (memRdAddr),
		.rdData (memRdData)
	);

	memPortArbiter memPortArbiter_inst
	(
		.clk       (clk),
		.rstN      (rstN),
		.hostValid (hostValid),
		.hostWrite (hostWrite),
		.hostAddr  (hostAddr),
		.hostWdata (hostWdata),
		.hostReady (hostReady),
		.hostGrant (hostGrant),
		.rdValid   (rdValid),
		.rdData    (rdData),
		.busy      (busy),
		.engRdEn   (engRdEn),
		.engRdAddr (engRdAddr),
		.engWrEn   (engWrEn),
		.engWrAddr (engWrAddr),
		.engWdata  (engWdata),
		.memRdData (memRdData),
		.memWrEn   (memWrEn),
		.memWrAddr (memWrAddr),
		.memWrData (memWrData),
		.memRdAddr (memRdAddr)
	);

	basicOps basicOps_inst
	(
		.opA        (opA),
		.opB        (opB),
		.opSel      (opSel),
		.opResult   (opResult),
		.opOverflow (opOverflow)
	);

	lspPrevUpdate lspPrevUpdate_inst
	(
		.clk          (clk),
		.rstN         (rstN),
		.startValid   (startValid),
		.startReady   (startReady),
		.busy         (busy),
		.done         (done),
		.hostGrant    (hostGrant),
		.freqPrevBase (freqPrevBase),
		.lspEleBase   (lspEleBase),
		.memRdData    (memRdData),
		.engRdEn      (engRdEn),
		.engRdAddr    (engRdAddr),
		.engWrEn      (engWrEn),
		.engWrAddr    (engWrAddr),
		.engWdata     (engWdata),
		.opResult     (opResult),
		.opOverflow   (opOverflow),
		.opA          (opA),
		.opB          (opB),
		.opSel        (opSel)
	);

endmodule

`default_nettype wire

/* logic/lspPrevUpdate.sv */
`default_nettype none

module lspPrevUpdate
(
	input  wire logic                          clk,
	input  wire logic                          rstN,

	// Start handshake and status
	input  wire logic                          startValid,
	output      logic                          startReady,
	output      logic                          busy,
	output      logic                          done,
	input  wire logic                          hostGrant,

	// Block bases
	input  wire logic [lspPkg::addrWidth-1:0]  freqPrevBase,
	input  wire logic [lspPkg::addrWidth-1:0]  lspEleBase,

	// Memory access through the arbiter
	input  wire logic [lspPkg::dataWidth-1:0]  memRdData,
	output      logic                          engRdEn,
	output      logic [lspPkg::addrWidth-1:0]  engRdAddr,
	output      logic                          engWrEn,
	output      logic [lspPkg::addrWidth-1:0]  engWrAddr,
	output      logic [lspPkg::dataWidth-1:0]  engWdata,

	// Shared operator unit
	input  wire logic [lspPkg::dataWidth-1:0]  opResult,
	input  wire logic                          opOverflow,
	output      logic [lspPkg::dataWidth-1:0]  opA,
	output      logic [lspPkg::dataWidth-1:0]  opB,
	output      logic                          opSel
);

	localparam int aw = lspPkg::addrWidth;
	localparam int dw = lspPkg::dataWidth;
	localparam int eb = lspPkg::elemBits;
	localparam int rb = lspPkg::rowBits;

	// Phases 0..maNp-2 move rows down and the last phase inserts lsp_ele
	localparam logic [rb-1:0] lastPhase = rb'(lspPkg::maNp - 1);
	localparam logic [rb-1:0] topSrcRow = rb'(lspPkg::maNp - 2);
	localparam logic [eb-1:0] lastElem = eb'(lspPkg::lpcOrder - 1);

	logic           rdActive;
	logic [rb-1:0]  phase;
	logic [eb-1:0]  elemIdx;
	logic [rb-1:0]  srcRow;
	logic [aw-1:0]  srcAddr;
	logic [aw-1:0]  dstAddr;
	logic           wrValid;
	logic [aw-1:0]  wrAddrQ;
	logic           startFire;
	logic           lastRead;

	////////////////////////////////////////////////////////////
	// Start and status
	////////////////////////////////////////////////////////////

	// Host request in the same cycle wins
	assign startReady = !busy && !hostGrant;
	assign startFire  = startValid && startReady;

	// Read phase plus the trailing write
	assign busy = rdActive || wrValid;

	assign lastRead = (phase == lastPhase) && (elemIdx == lastElem);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			rdActive <= 1'b0;
			phase    <= '0;
			elemIdx  <= '0;
		end
		else if (startFire)
		begin
			rdActive <= 1'b1;
			phase    <= '0;
			elemIdx  <= '0;
		end
		else if (rdActive)
		begin
			if (elemIdx == lastElem)
			begin
				elemIdx <= '0;
				phase   <= phase + 1'b1;
			end
			else
			begin
				elemIdx <= elemIdx + 1'b1;
			end
			if (lastRead)
				rdActive <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Address generation
	////////////////////////////////////////////////////////////

	assign srcRow = topSrcRow - phase;

	always_comb
	begin
		if (phase == lastPhase)
		begin
			srcAddr = {lspEleBase[aw-1:eb], elemIdx};
			// lsp_ele always lands in row 0
			dstAddr = {freqPrevBase[aw-1:rb+eb], {rb{1'b0}}, elemIdx};
		end
		else
		begin
			srcAddr = {freqPrevBase[aw-1:rb+eb], srcRow, elemIdx};
			dstAddr = opResult[aw-1:0];
		end
	end

	// Next row down is one stride further
	assign opA   = {{(dw-aw){1'b0}}, srcAddr};
	assign opB   = dw'(lspPkg::rowStride);
	assign opSel = lspPkg::opAdd;

	assign engRdEn   = rdActive;
	assign engRdAddr = srcAddr;

	////////////////////////////////////////////////////////////
	// Write stage
	////////////////////////////////////////////////////////////

	// Pairs the destination with the read data of the next cycle
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrValid <= 1'b0;
			done    <= 1'b0;
		end
		else
		begin
			wrValid <= rdActive;
			done    <= wrValid && !rdActive;
		end
	end

	always_ff @(posedge clk)
	begin
		wrAddrQ <= dstAddr;
	end

	assign engWrEn   = wrValid;
	assign engWrAddr = wrAddrQ;
	assign engWdata  = memRdData;

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!rstN) busy |-> !opOverflow)
		else $error("address arithmetic overflowed during update");

	// Done follows every start at the fixed latency
	assert property (@(posedge clk) disable iff (!rstN)
		startFire |-> ##(lspPkg::updateLatency) done)
		else $error("done missing at fixed latency after start");

endmodule

`default_nettype wire

/* logic/memPortArbiter.sv */
`default_nettype none

module memPortArbiter
(
	input  wire logic                          clk,
	input  wire logic                          rstN,

	// Host request side
	input  wire logic                          hostValid,
	input  wire logic                          hostWrite,
	input  wire logic [lspPkg::addrWidth-1:0]  hostAddr,
	input  wire logic [lspPkg::dataWidth-1:0]  hostWdata,
	output      logic                          hostReady,
	output      logic                          hostGrant,
	output      logic                          rdValid,
	output      logic [lspPkg::dataWidth-1:0]  rdData,

	// Engine side
	input  wire logic                          busy,
	input  wire logic                          engRdEn,
	input  wire logic [lspPkg::addrWidth-1:0]  engRdAddr,
	input  wire logic                          engWrEn,
	input  wire logic [lspPkg::addrWidth-1:0]  engWrAddr,
	input  wire logic [lspPkg::dataWidth-1:0]  engWdata,

	// Memory side
	input  wire logic [lspPkg::dataWidth-1:0]  memRdData,
	output      logic                          memWrEn,
	output      logic [lspPkg::addrWidth-1:0]  memWrAddr,
	output      logic [lspPkg::dataWidth-1:0]  memWrData,
	output      logic [lspPkg::addrWidth-1:0]  memRdAddr
);

	logic rdPending;

	////////////////////////////////////////////////////////////
	// Host handshake
	////////////////////////////////////////////////////////////

	// Host waits for the whole update
	assign hostReady = !busy;
	assign hostGrant = hostValid && hostReady;

	////////////////////////////////////////////////////////////
	// Port muxes
	////////////////////////////////////////////////////////////

	always_comb
	begin
		if (busy)
		begin
			memWrEn   = engWrEn;
			memWrAddr = engWrAddr;
			memWrData = engWdata;
		end
		else
		begin
			memWrEn   = hostGrant && hostWrite;
			memWrAddr = hostAddr;
			memWrData = hostWdata;
		end
	end

	// Read address follows the engine only while it is reading
	assign memRdAddr = (busy && engRdEn) ? engRdAddr : hostAddr;

	// Fixed one cycle read latency, no back-pressure
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			rdPending <= 1'b0;
		else
			rdPending <= hostGrant && !hostWrite;
	end

	assign rdValid = rdPending;
	assign rdData  = memRdData;

	// Engine write and granted host write must never collide
	assert property (@(posedge clk) disable iff (!rstN)
		!(engWrEn && hostGrant && hostWrite))
		else $error("memory write from host and engine in the same cycle");

endmodule

`default_nettype wire

/* logic/basicOps.sv */
`default_nettype none

module basicOps
(
	input  wire logic [lspPkg::dataWidth-1:0]  opA,
	input  wire logic [lspPkg::dataWidth-1:0]  opB,
	input  wire logic                          opSel,
	output      logic [lspPkg::dataWidth-1:0]  opResult,
	output      logic                          opOverflow
);

	localparam int w = lspPkg::dataWidth;

	localparam logic [w-1:0] maxPos = {1'b0, {(w-1){1'b1}}};
	localparam logic [w-1:0] maxNeg = {1'b1, {(w-1){1'b0}}};

	// One guard bit above the sign
	logic [w:0] extA;
	logic [w:0] extB;
	logic [w:0] rawSum;

	assign extA = {opA[w-1], opA};
	assign extB = {opB[w-1], opB};

	assign rawSum = (opSel == lspPkg::opSub) ? (extA - extB) : (extA + extB);

	// Guard and sign differ when the true result leaves 16 bits
	assign opOverflow = rawSum[w] ^ rawSum[w-1];

	// Clamp toward the sign of the true result
	always_comb
	begin
		if (!opOverflow)
			opResult = rawSum[w-1:0];
		else if (rawSum[w])
			opResult = maxNeg;
		else
			opResult = maxPos;
	end

endmodule

`default_nettype wire

/* logic/scratchMemory.sv */
`default_nettype none

module scratchMemory
(
	input  wire logic                          clk,
	input  wire logic                          wrEn,
	input  wire logic [lspPkg::addrWidth-1:0]  wrAddr,
	input  wire logic [lspPkg::dataWidth-1:0]  wrData,
	input  wire logic [lspPkg::addrWidth-1:0]  rdAddr,
	output      logic [lspPkg::dataWidth-1:0]  rdData
);

	localparam int depth = 1 << lspPkg::addrWidth;

	// Holds the freq_prev rows, lsp_ele and any other codec scratch data
	logic [lspPkg::dataWidth-1:0] mem [0:depth-1];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (wrEn)
		begin
			mem[wrAddr] <= wrData;
		end
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	// Data appears one cycle after the address
	always_ff @(posedge clk)
	begin
		rdData <= mem[rdAddr];
	end

endmodule

`default_nettype wire

/* logic/lspPkg.sv */
`default_nettype none

package lspPkg;

	////////////////////////////////////////////////////////////
	// Scratch memory geometry
	////////////////////////////////////////////////////////////

	localparam int dataWidth = 16;
	localparam int addrWidth = 11;

	////////////////////////////////////////////////////////////
	// LSP history layout
	////////////////////////////////////////////////////////////

	// Coefficients per vector (M)
	localparam int lpcOrder = 10;
	// History rows (MA_NP)
	localparam int maNp = 4;

	// Address fields below the block base
	localparam int elemBits = 4;
	localparam int rowBits = 2;

	// One history row is one 16-word slot
	localparam int rowStride = 16;

	////////////////////////////////////////////////////////////
	// Basic operator codes
	////////////////////////////////////////////////////////////

	localparam logic opAdd = 1'b0;
	localparam logic opSub = 1'b1;

	// Accepted start to done pulse, in cycles
	localparam int updateLatency = 42;

endpackage

`default_nettype wire
